//--- hdl/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

  // ================================================
  // Widths
  // ================================================
  localparam int data_w     = 32;
  localparam int line_words = 4;
  localparam int line_w     = data_w * line_words;
  localparam int line_bytes = line_w / 8;
  // Byte offset inside one line
  localparam int offset_w   = $clog2(line_bytes);

  // ================================================
  // Access types
  // ================================================
  localparam int type_w = 3;

  // Only the low two bits are decoded and code 3 acts as a word
  localparam logic [type_w-1:0] acc_byte  = 3'd0;
  localparam logic [type_w-1:0] acc_hword = 3'd1;
  localparam logic [type_w-1:0] acc_word  = 3'd2;

  // ================================================
  // Cache line
  // ================================================
  // Word view for loads and refill, byte view for the store merge
  typedef union packed {
    logic [line_words-1:0][data_w-1:0] words;
    logic [line_bytes-1:0][7:0]        bytes;
  } cache_line_u;

endpackage

`default_nettype wire

//--- hdl/dcache_if.sv
`timescale 1ns/1ps
`default_nettype none

// Captured request fields
interface req_if #(
  parameter int num_lines = 64
);
  localparam int index_w = $clog2(num_lines);
  localparam int tag_w   = dcache_pkg::data_w - index_w - dcache_pkg::offset_w;

  logic                            capture;
  logic [index_w-1:0]              index;
  logic [tag_w-1:0]                tag;
  logic                            write;
  dcache_pkg::cache_line_u         wline;
  logic [dcache_pkg::line_bytes-1:0] wmask;
  logic [1:0]                      word_sel;
  logic [dcache_pkg::data_w-1:0]   addr;
  logic [dcache_pkg::data_w-1:0]   fill_addr;
  logic [dcache_pkg::type_w-1:0]   acc_type;

  modport decode (
    input  capture,
    output index, tag, write, wline, wmask, word_sel, addr, fill_addr, acc_type
  );
  modport ctrl (
    output capture,
    input  index, tag, write, wline, wmask, addr, fill_addr, acc_type
  );
  modport result (
    input  word_sel
  );
endinterface

// Tag and data array port
interface array_if #(
  parameter int num_lines = 64
);
  localparam int index_w = $clog2(num_lines);
  localparam int tag_w   = dcache_pkg::data_w - index_w - dcache_pkg::offset_w;

  logic [index_w-1:0]                index;
  logic [tag_w-1:0]                  tag_in;
  logic                              tag_we;
  dcache_pkg::cache_line_u           line_in;
  logic [dcache_pkg::line_bytes-1:0] wmask;
  logic                              rd_en;
  logic [tag_w-1:0]                  tag_out;
  dcache_pkg::cache_line_u           line_out;

  modport ctrl (
    output index, tag_in, tag_we, line_in, wmask, rd_en,
    input  tag_out, line_out
  );
  modport array (
    input  index, tag_in, tag_we, line_in, wmask, rd_en,
    output tag_out, line_out
  );
endinterface

// Load data and event pulses
interface result_if;
  logic                    load;
  dcache_pkg::cache_line_u load_line;
  logic                    hit_ev;
  logic                    miss_ev;

  modport ctrl (output load, load_line, hit_ev, miss_ev);
  modport result (input load, load_line, hit_ev, miss_ev);
endinterface

`default_nettype wire

//--- hdl/dcache_req_decode.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_req_decode #(
  parameter int num_lines = 64
) (
  input  wire logic                              clk,
  input  wire logic                              rstn,
  input  wire logic [dcache_pkg::data_w-1:0]     core_addr,
  input  wire logic                              core_write,
  input  wire logic [dcache_pkg::data_w-1:0]     core_wdata,
  input  wire logic [dcache_pkg::type_w-1:0]     core_type,
  req_if.decode                                  req
);

  localparam int index_w = $clog2(num_lines);
  localparam int tag_w   = dcache_pkg::data_w - index_w - dcache_pkg::offset_w;

  logic [dcache_pkg::data_w-1:0] addr_q;
  logic [dcache_pkg::data_w-1:0] wdata_q;
  logic [dcache_pkg::type_w-1:0] type_q;
  logic                          write_q;
  logic [1:0]                    byte_off;
  logic [3:0]                    lane_mask;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      write_q <= 1'b0;
      type_q  <= dcache_pkg::acc_word;
    end else if (req.capture) begin
      write_q <= core_write;
      type_q  <= core_type;
    end
  end

  always_ff @(posedge clk) begin
    if (req.capture) begin
      addr_q  <= core_addr;
      wdata_q <= core_wdata;
    end
  end

  // Live fields while idle so the array read starts in the request cycle
  assign req.index = req.capture ? core_addr[dcache_pkg::offset_w +: index_w]
                                 : addr_q[dcache_pkg::offset_w +: index_w];
  assign req.tag   = req.capture ? core_addr[dcache_pkg::data_w-1 -: tag_w]
                                 : addr_q[dcache_pkg::data_w-1 -: tag_w];
  assign req.write = req.capture ? core_write : write_q;

  assign req.addr      = addr_q;
  assign req.fill_addr = {addr_q[dcache_pkg::data_w-1:dcache_pkg::offset_w],
                          {dcache_pkg::offset_w{1'b0}}};
  assign req.word_sel  = addr_q[3:2];
  assign req.acc_type  = type_q;
  assign req.wline     = {dcache_pkg::line_words{wdata_q}};

  // ================================================
  // Byte write mask
  // ================================================
  assign byte_off = addr_q[1:0];

  always_comb begin
    case (type_q[1:0])
      dcache_pkg::acc_byte[1:0]:  lane_mask = 4'b0001 << byte_off;
      dcache_pkg::acc_hword[1:0]: lane_mask = byte_off[1] ? 4'b1100 : 4'b0011;
      default:                    lane_mask = 4'b1111;
    endcase
  end

  // Lanes moved to the selected word
  assign req.wmask = {12'h000, lane_mask} << {req.word_sel, 2'b00};

  a_mask_nonzero : assert property (
    @(posedge clk) disable iff (!rstn)
    !req.capture |-> (req.wmask != '0)
  );

endmodule

`default_nettype wire

//--- hdl/dcache_arrays.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_arrays #(
  parameter int num_lines = 64
) (
  input  wire logic clk,
  array_if.array    arr
);

  localparam int index_w = $clog2(num_lines);
  localparam int tag_w   = dcache_pkg::data_w - index_w - dcache_pkg::offset_w;

  logic [tag_w-1:0]        tag_mem  [num_lines];
  dcache_pkg::cache_line_u line_mem [num_lines];

  // ================================================
  // Tag array
  // ================================================
  always_ff @(posedge clk) begin
    if (arr.tag_we) begin
      tag_mem[arr.index] <= arr.tag_in;
    end
  end

  always_ff @(posedge clk) begin
    if (arr.rd_en) begin
      arr.tag_out <= tag_mem[arr.index];
    end
  end

  // ================================================
  // Data array
  // ================================================
  // Byte lanes written under the mask
  always_ff @(posedge clk) begin
    for (int b = 0; b < dcache_pkg::line_bytes; b++) begin
      if (arr.wmask[b]) begin
        line_mem[arr.index].bytes[b] <= arr.line_in.bytes[b];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (arr.rd_en) begin
      arr.line_out <= line_mem[arr.index];
    end
  end

  // Refill tag write lands outside any lookup
  a_no_rw_clash : assert property (
    @(posedge clk) !(arr.tag_we && arr.rd_en)
  );

endmodule

`default_nettype wire

//--- hdl/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl #(
  parameter int num_lines = 64
) (
  input  wire logic                          clk,
  input  wire logic                          rstn,
  input  wire logic                          core_req,
  output logic                               core_wait,
  output logic                               mem_req,
  output logic                               mem_write,
  output logic [dcache_pkg::data_w-1:0]      mem_addr,
  output logic [dcache_pkg::data_w-1:0]      mem_wdata,
  output logic [dcache_pkg::type_w-1:0]      mem_type,
  input  wire logic                          mem_ack,
  input  wire logic [dcache_pkg::data_w-1:0] mem_rdata,
  req_if.ctrl                                req,
  array_if.ctrl                              arr,
  result_if.ctrl                             res
);

  typedef enum logic [2:0] {
    st_idle,
    st_check,
    st_whit,
    st_wmiss,
    st_rmiss
  } state_e;

  state_e                  state;
  state_e                  next_state;
  logic [num_lines-1:0]    valid;
  logic [2:0]              ack_cnt;
  logic                    issued_q;
  logic                    tail_q;
  dcache_pkg::cache_line_u fill_buf;
  dcache_pkg::cache_line_u fill_next;
  logic                    accept;
  logic                    tag_hit;
  logic                    fill_done;

  assign req.capture = (state == st_idle) && !tail_q;
  assign core_wait   = (state != st_idle) || tail_q;
  assign accept      = core_req && req.capture;
  assign tag_hit     = (arr.tag_out == req.tag);
  assign fill_done   = (state == st_rmiss) && mem_ack && (ack_cnt == 3'd3);

  // ================================================
  // State machine
  // ================================================
  always_comb begin
    next_state = state;
    case (state)
      st_idle: begin
        if (accept) begin
          if (!valid[req.index]) begin
            next_state = req.write ? st_wmiss : st_rmiss;
          end else begin
            next_state = st_check;
          end
        end
      end
      st_check: begin
        if (req.write) begin
          next_state = tag_hit ? st_whit : st_wmiss;
        end else begin
          next_state = tag_hit ? st_idle : st_rmiss;
        end
      end
      st_whit, st_wmiss: begin
        if (mem_ack) begin
          next_state = st_idle;
        end
      end
      st_rmiss: begin
        if (fill_done) begin
          next_state = st_idle;
        end
      end
      default: next_state = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state    <= st_idle;
      tail_q   <= 1'b0;
      issued_q <= 1'b0;
      ack_cnt  <= 3'd0;
      valid    <= '0;
    end else begin
      state <= next_state;
      // One closing cycle after every access
      tail_q <= (state != st_idle) && (next_state == st_idle);
      if (state == st_idle) begin
        issued_q <= 1'b0;
        ack_cnt  <= 3'd0;
      end else begin
        if (mem_req) begin
          issued_q <= 1'b1;
        end
        if ((state == st_rmiss) && mem_ack) begin
          ack_cnt <= ack_cnt + 3'd1;
        end
      end
      if (fill_done) begin
        valid[req.index] <= 1'b1;
      end
    end
  end

  // ================================================
  // Refill buffer
  // ================================================
  always_comb begin
    fill_next.words[dcache_pkg::line_words-1] = mem_rdata;
    for (int w = 0; w < dcache_pkg::line_words - 1; w++) begin
      fill_next.words[w] = fill_buf.words[w+1];
    end
  end

  always_ff @(posedge clk) begin
    if ((state == st_rmiss) && mem_ack) begin
      fill_buf <= fill_next;
    end
  end

  // Arrays
  assign arr.index   = req.index;
  assign arr.rd_en   = accept;
  assign arr.tag_in  = req.tag;
  assign arr.tag_we  = fill_done;
  assign arr.line_in = (state == st_rmiss) ? fill_next : req.wline;
  assign arr.wmask   = fill_done ? '1 :
                       ((state == st_whit) && mem_ack) ? req.wmask : '0;

  // Result path
  assign res.load      = ((state == st_check) && tag_hit && !req.write) || fill_done;
  assign res.load_line = (state == st_rmiss) ? fill_next : arr.line_out;
  assign res.hit_ev    = (state == st_check) && tag_hit;
  assign res.miss_ev   = ((state == st_check) && !tag_hit) ||
                         (accept && !valid[req.index]);

  // One memory request per access
  assign mem_req   = (state inside {st_whit, st_wmiss, st_rmiss}) && !issued_q;
  assign mem_write = mem_req && (state != st_rmiss);
  assign mem_addr  = (state == st_rmiss) ? req.fill_addr : req.addr;
  assign mem_wdata = req.wline.words[0];
  assign mem_type  = (state == st_rmiss) ? dcache_pkg::acc_word : req.acc_type;

  a_mem_req_pulse : assert property (
    @(posedge clk) disable iff (!rstn)
    mem_req |-> !(state inside {st_idle, st_check}) ##1 !mem_req
  );

  a_fill_ack_limit : assert property (
    @(posedge clk) disable iff (!rstn)
    (state == st_rmiss) && mem_ack |-> issued_q && (ack_cnt <= 3'd3)
  );

endmodule

`default_nettype wire

//--- hdl/dcache_result.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_result (
  input  wire logic                     clk,
  input  wire logic                     rstn,
  result_if.result                      res,
  req_if.result                         req,
  output logic [dcache_pkg::data_w-1:0] core_rdata,
  output logic [dcache_pkg::data_w-1:0] hit_count,
  output logic [dcache_pkg::data_w-1:0] miss_count
);

  logic [dcache_pkg::data_w-1:0] load_word;

  assign load_word = res.load_line.words[req.word_sel];

  // Held until the next load
  always_ff @(posedge clk) begin
    if (res.load) begin
      core_rdata <= load_word;
    end
  end

  // ================================================
  // Statistics
  // ================================================
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      hit_count  <= '0;
      miss_count <= '0;
    end else begin
      if (res.hit_ev) begin
        hit_count <= hit_count + 1'b1;
      end
      if (res.miss_ev) begin
        miss_count <= miss_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
  parameter int num_lines = 64
) (
  input  wire logic                          clk,
  input  wire logic                          rstn,
  // Core side
  input  wire logic                          core_req,
  input  wire logic                          core_write,
  input  wire logic [dcache_pkg::data_w-1:0] core_addr,
  input  wire logic [dcache_pkg::data_w-1:0] core_wdata,
  input  wire logic [dcache_pkg::type_w-1:0] core_type,
  output logic      [dcache_pkg::data_w-1:0] core_rdata,
  output logic                               core_wait,
  output logic      [dcache_pkg::data_w-1:0] hit_count,
  output logic      [dcache_pkg::data_w-1:0] miss_count,
  // Memory side
  output logic                               mem_req,
  output logic                               mem_write,
  output logic      [dcache_pkg::data_w-1:0] mem_addr,
  output logic      [dcache_pkg::data_w-1:0] mem_wdata,
  output logic      [dcache_pkg::type_w-1:0] mem_type,
  input  wire logic                          mem_ack,
  input  wire logic [dcache_pkg::data_w-1:0] mem_rdata
);

  req_if   #(.num_lines(num_lines)) req_bus ();
  array_if #(.num_lines(num_lines)) arr_bus ();
  result_if                         res_bus ();

  dcache_req_decode #(.num_lines(num_lines)) u_decode (
    .clk        (clk),
    .rstn       (rstn),
    .core_addr  (core_addr),
    .core_write (core_write),
    .core_wdata (core_wdata),
    .core_type  (core_type),
    .req        (req_bus.decode)
  );

  dcache_ctrl #(.num_lines(num_lines)) u_ctrl (
    .clk       (clk),
    .rstn      (rstn),
    .core_req  (core_req),
    .core_wait (core_wait),
    .mem_req   (mem_req),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_type  (mem_type),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata),
    .req       (req_bus.ctrl),
    .arr       (arr_bus.ctrl),
    .res       (res_bus.ctrl)
  );

  dcache_arrays #(.num_lines(num_lines)) u_arrays (
    .clk (clk),
    .arr (arr_bus.array)
  );

  dcache_result u_result (
    .clk        (clk),
    .rstn       (rstn),
    .res        (res_bus.result),
    .req        (req_bus.result),
    .core_rdata (core_rdata),
    .hit_count  (hit_count),
    .miss_count (miss_count)
  );

endmodule

`default_nettype wire

//--- verification/dcache_checker.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_checker #(
  parameter int num_lines = 16
) (
  input  wire logic                          clk,
  input  wire logic                          rstn,
  input  wire logic                          core_req,
  input  wire logic                          core_write,
  input  wire logic [dcache_pkg::data_w-1:0] core_addr,
  input  wire logic [dcache_pkg::data_w-1:0] core_wdata,
  input  wire logic [dcache_pkg::type_w-1:0] core_type,
  input  wire logic [dcache_pkg::data_w-1:0] core_rdata,
  input  wire logic                          core_wait,
  input  wire logic [dcache_pkg::data_w-1:0] hit_count,
  input  wire logic [dcache_pkg::data_w-1:0] miss_count,
  input  wire logic                          mem_req,
  input  wire logic                          mem_write,
  input  wire logic [dcache_pkg::data_w-1:0] mem_addr,
  input  wire logic [dcache_pkg::data_w-1:0] mem_wdata,
  input  wire logic [dcache_pkg::type_w-1:0] mem_type,
  input  wire logic                          mem_ack,
  input  wire logic                          test_done,
  input  wire logic [7:0]                    test_idx,
  output int                                 error_count,
  output int                                 op_count
);

  localparam int index_w = $clog2(num_lines);
  localparam int tag_w   = dcache_pkg::data_w - index_w - dcache_pkg::offset_w;

  logic [31:0]          ref_mem [256];
  logic [tag_w-1:0]     tag_tab [num_lines];
  logic [num_lines-1:0] valid_tab;
  logic                 busy;
  logic                 op_write;
  logic                 op_hit;
  logic [31:0]          op_addr;
  logic [31:0]          op_wdata;
  logic [31:0]          op_expect;
  logic [2:0]           op_type;
  int                   wait_cycles;
  int                   mem_reqs;
  int                   ack_seen;
  int                   model_hits;
  int                   model_misses;
  int                   test_ops;
  int                   test_err_base;

  function automatic logic [31:0] init_word(input int i);
    return (32'(i) * 32'h9e37_79b1) ^ 32'h5a5a_0000;
  endfunction

  // Stored byte, halfword or word replaces its slice of the old word
  function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [31:0] data,
                                              input logic [2:0] typ, input logic [1:0] off);
    logic [31:0] res;
    res = old;
    if (typ[1:0] == 2'd0) begin
      res[8*off +: 8] = data[8*off +: 8];
    end else if (typ[1:0] == 2'd1) begin
      res[16*off[1] +: 16] = data[16*off[1] +: 16];
    end else begin
      res = data;
    end
    return res;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("mismatch at %0t ns: %s", $time, msg);
    error_count++;
  endtask

  task automatic report_failure(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    error_count++;
  endtask

  task automatic check_counters();
    if (hit_count != model_hits || miss_count != model_misses) begin
      report_mismatch($sformatf("counters hit %0d miss %0d, expected hit %0d miss %0d",
                                hit_count, miss_count, model_hits, model_misses));
    end
  endtask

  // ==================================================
  // Reference cache
  // ==================================================
  task automatic start_access();
    logic [index_w-1:0] idx;
    logic [tag_w-1:0]   tag;
    logic [7:0]         word;
    idx      = core_addr[dcache_pkg::offset_w +: index_w];
    tag      = core_addr[dcache_pkg::data_w-1 -: tag_w];
    word     = core_addr[9:2];
    op_write = core_write;
    op_addr  = core_addr;
    op_wdata = core_wdata;
    op_type  = core_type;
    op_hit   = valid_tab[idx] && (tag_tab[idx] == tag);
    if (op_hit) begin
      model_hits++;
    end else begin
      model_misses++;
    end
    if (core_write) begin
      ref_mem[word] = merge_store(ref_mem[word], core_wdata, core_type, core_addr[1:0]);
    end else if (!op_hit) begin
      valid_tab[idx] = 1'b1;
      tag_tab[idx]   = tag;
    end
    op_expect   = ref_mem[word];
    busy        = 1'b1;
    wait_cycles = 0;
    mem_reqs    = 0;
    ack_seen    = 0;
  endtask

  task automatic check_mem_request();
    mem_reqs++;
    if (op_write) begin
      if (!mem_write || mem_addr != op_addr || mem_wdata != op_wdata || mem_type != op_type) begin
        report_mismatch($sformatf("store request addr 0x%08h data 0x%08h type %0d",
                                  mem_addr, mem_wdata, mem_type));
      end
    end else if (op_hit) begin
      report_failure($sformatf("read hit at 0x%08h issued a memory request", op_addr));
    end else if (mem_write || mem_addr != {op_addr[31:4], 4'h0} ||
                 mem_type != dcache_pkg::acc_word) begin
      report_mismatch($sformatf("refill request addr 0x%08h type %0d for 0x%08h",
                                mem_addr, mem_type, op_addr));
    end
  endtask

  task automatic finish_access();
    if (op_write && (mem_reqs != 1 || ack_seen != 1)) begin
      report_mismatch($sformatf("store to 0x%08h reached memory %0d times", op_addr, mem_reqs));
    end
    if (!op_write && op_hit && wait_cycles != 2) begin
      report_mismatch($sformatf("read hit took %0d cycles", wait_cycles));
    end
    if (!op_write && !op_hit && (mem_reqs != 1 || ack_seen != 4)) begin
      report_mismatch($sformatf("refill used %0d requests and %0d acks", mem_reqs, ack_seen));
    end
    if (!op_write && core_rdata != op_expect) begin
      report_mismatch($sformatf("read 0x%08h returned 0x%08h, expected 0x%08h",
                                op_addr, core_rdata, op_expect));
    end
    check_counters();
    busy = 1'b0;
    op_count++;
    test_ops++;
  endtask

  // Samples pre-edge values of the DUT outputs
  always @(posedge clk) begin
    if (!rstn) begin
      for (int i = 0; i < 256; i++) begin
        ref_mem[i] = init_word(i);
      end
      valid_tab     = '0;
      busy          = 1'b0;
      error_count   = 0;
      op_count      = 0;
      model_hits    = 0;
      model_misses  = 0;
      test_ops      = 0;
      test_err_base = 0;
    end else begin
      if (mem_req && !busy) begin
        report_failure("memory request outside an access");
      end
      if (busy) begin
        if (mem_req) begin
          check_mem_request();
        end
        if (mem_ack) begin
          ack_seen++;
        end
        if (core_wait) begin
          wait_cycles++;
        end else begin
          finish_access();
        end
      end
      if (core_req && !core_wait) begin
        start_access();
      end
      if (test_done) begin
        check_counters();
        $display("test %0d finished: %0d accesses, %0d errors",
                 test_idx, test_ops, error_count - test_err_base);
        test_ops      = 0;
        test_err_base = error_count;
      end
    end
  end

endmodule

`default_nettype wire

//--- verification/tb_dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_top;

  localparam int num_lines     = 16;
  localparam int n_directed    = 8;
  localparam int n_random      = 300;
  localparam int total_ops     = n_directed + n_random;
  localparam int cycles_per_op = 40;
  localparam int clk_period    = 100;

  logic        clk;
  logic        rstn;
  logic        core_req;
  logic        core_write;
  logic [31:0] core_addr;
  logic [31:0] core_wdata;
  logic [2:0]  core_type;
  logic [31:0] core_rdata;
  logic        core_wait;
  logic [31:0] hit_count;
  logic [31:0] miss_count;
  logic        mem_req;
  logic        mem_write;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [2:0]  mem_type;
  logic        mem_ack;
  logic [31:0] mem_rdata;
  logic        test_done;
  logic [7:0]  test_idx;
  int          error_count;
  int          op_count;
  logic [31:0] drv_state;
  logic [31:0] mem_state;
  logic [31:0] mem_array [256];

  initial clk = 1'b0;
  always #(clk_period / 2) clk = ~clk;

  dcache_top #(.num_lines(num_lines)) u_dut (
    .clk (clk), .rstn (rstn),
    .core_req (core_req), .core_write (core_write), .core_addr (core_addr),
    .core_wdata (core_wdata), .core_type (core_type), .core_rdata (core_rdata),
    .core_wait (core_wait), .hit_count (hit_count), .miss_count (miss_count),
    .mem_req (mem_req), .mem_write (mem_write), .mem_addr (mem_addr),
    .mem_wdata (mem_wdata), .mem_type (mem_type), .mem_ack (mem_ack),
    .mem_rdata (mem_rdata)
  );

  dcache_checker #(.num_lines(num_lines)) u_check (
    .clk (clk), .rstn (rstn),
    .core_req (core_req), .core_write (core_write), .core_addr (core_addr),
    .core_wdata (core_wdata), .core_type (core_type), .core_rdata (core_rdata),
    .core_wait (core_wait), .hit_count (hit_count), .miss_count (miss_count),
    .mem_req (mem_req), .mem_write (mem_write), .mem_addr (mem_addr),
    .mem_wdata (mem_wdata), .mem_type (mem_type), .mem_ack (mem_ack),
    .test_done (test_done), .test_idx (test_idx),
    .error_count (error_count), .op_count (op_count)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] fill_word(input int i);
    return (32'(i) * 32'h9e37_79b1) ^ 32'h5a5a_0000;
  endfunction

  function automatic logic [31:0] apply_store(input logic [31:0] old, input logic [31:0] data,
                                              input logic [2:0] typ, input logic [1:0] off);
    logic [31:0] res;
    res = old;
    case (typ[1:0])
      2'd0:    res[8*off +: 8] = data[8*off +: 8];
      2'd1:    res[16*off[1] +: 16] = data[16*off[1] +: 16];
      default: res = data;
    endcase
    return res;
  endfunction

  // ==================================================
  // Memory model
  // ==================================================
  // First ack at least one cycle after the request
  task automatic serve_request();
    logic [31:0] addr;
    logic        wr;
    int          n_acks;
    int          gap;
    addr = mem_addr;
    wr   = mem_write;
    if (wr) begin
      mem_array[addr[9:2]] = apply_store(mem_array[addr[9:2]], mem_wdata, mem_type, addr[1:0]);
    end
    n_acks = wr ? 1 : 4;
    for (int k = 0; k < n_acks; k++) begin
      mem_state = xorshift32(mem_state);
      gap       = int'(mem_state[1:0]) + ((k == 0) ? 1 : 0);
      repeat (gap) @(negedge clk);
      mem_ack   = 1'b1;
      mem_rdata = wr ? 32'h0 : mem_array[{addr[9:4], 2'(k)}];
      @(negedge clk);
      mem_ack = 1'b0;
    end
  endtask

  initial begin
    mem_ack   = 1'b0;
    mem_rdata = 32'h0;
    mem_state = xorshift32(xorshift32(32'h9c5));
    for (int i = 0; i < 256; i++) begin
      mem_array[i] = fill_word(i);
    end
    forever begin
      @(negedge clk);
      if (rstn && mem_req) begin
        serve_request();
      end
    end
  end

  // ==================================================
  // Core side stimulus
  // ==================================================
  task automatic run_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [2:0] typ);
    while (core_wait) @(negedge clk);
    core_req   = 1'b1;
    core_write = wr;
    core_addr  = addr;
    core_wdata = wdata;
    core_type  = typ;
    @(negedge clk);
    core_req = 1'b0;
    while (core_wait) @(negedge clk);
  endtask

  // 9-bit addresses give two tags per index
  task automatic random_access();
    logic [31:0] r;
    logic [31:0] addr;
    logic [2:0]  typ;
    drv_state = xorshift32(drv_state);
    r         = drv_state;
    typ       = {1'b0, r[4:3]};
    addr      = {23'd0, r[13:5]};
    if (typ == 3'd1) begin
      addr[0] = 1'b0;
    end else if (typ != 3'd0) begin
      addr[1:0] = 2'b00;
    end
    drv_state = xorshift32(drv_state);
    run_access(r[2:0] < 3'd3, addr, drv_state, typ);
  endtask

  task automatic finish_test(input logic [7:0] idx);
    test_idx  = idx;
    test_done = 1'b1;
    @(negedge clk);
    test_done = 1'b0;
  endtask

  initial begin
    rstn       = 1'b0;
    core_req   = 1'b0;
    core_write = 1'b0;
    core_addr  = 32'h0;
    core_wdata = 32'h0;
    core_type  = dcache_pkg::acc_word;
    test_done  = 1'b0;
    test_idx   = 8'd0;
    drv_state  = 32'h9c5;
    repeat (2) @(negedge clk);
    rstn = 1'b1;

    // Cold miss, then hits in the same line
    run_access(1'b0, 32'h040, 32'h0, dcache_pkg::acc_word);
    run_access(1'b0, 32'h040, 32'h0, dcache_pkg::acc_word);
    run_access(1'b0, 32'h044, 32'h0, dcache_pkg::acc_word);
    finish_test(8'd0);

    // Write miss leaves the line unallocated
    run_access(1'b1, 32'h180, 32'hcafe_f00d, dcache_pkg::acc_word);
    run_access(1'b0, 32'h180, 32'h0, dcache_pkg::acc_word);
    run_access(1'b1, 32'h183, 32'h7700_0000, dcache_pkg::acc_byte);
    run_access(1'b1, 32'h182, 32'h1234_5678, dcache_pkg::acc_hword);
    run_access(1'b0, 32'h180, 32'h0, dcache_pkg::acc_word);
    finish_test(8'd1);

    repeat (n_random) random_access();
    finish_test(8'd2);

    @(negedge clk);
    $display("summary: %0d accesses, %0d hits, %0d misses, %0d errors",
             op_count, hit_count, miss_count, error_count);
    if (error_count == 0 && op_count == total_ops) begin
      $display("TEST RESULT: PASS");
    end else begin
      if (op_count != total_ops) begin
        $display("only %0d of %0d accesses were checked", op_count, total_ops);
      end
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(total_ops * cycles_per_op * clk_period);
    $display("timeout: run did not finish within %0d cycles", total_ops * cycles_per_op);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- dcache_top.f
hdl/dcache_pkg.sv
hdl/dcache_if.sv
hdl/dcache_req_decode.sv
hdl/dcache_arrays.sv
hdl/dcache_ctrl.sv
hdl/dcache_result.sv
hdl/dcache_top.sv
verification/dcache_checker.sv
verification/tb_dcache_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache_top \
  -f dcache_top.f -o sim_dcache \
  && ./obj_dir/sim_dcache > sim.log 2>&1 \
  || echo "build or simulation did not complete"
[ -f sim.log ] && cat sim.log
grep -qs "TEST RESULT: PASS" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
